// ==== icache_fill_pkg.sv ====
/*
 * Instruction cache line-fill definitions
 * Widths, address field positions, the transaction-id layout and the
 * miss requester state encoding shared by every block of the fill path
 */
`default_nettype none

package icache_fill_pkg;

	// ==========================================================
	// Widths and sizes
	// ==========================================================
	localparam int ADDR_W    = 32;
	localparam int BEAT_W    = 128;
	localparam int LINE_W    = 512;
	localparam int NUM_BEATS = LINE_W / BEAT_W;
	localparam int LOG_BEATS = 2;
	localparam int LOG_WAYS  = 2;
	localparam int NUM_WAYS  = 1 << LOG_WAYS;
	localparam int LOG_SETS  = 4;
	localparam int NUM_SETS  = 1 << LOG_SETS;
	localparam int LOG_SLOTS = 2;
	localparam int NUM_SLOTS = 1 << LOG_SLOTS;

	// ==========================================================
	// Address fields and transaction id
	// ==========================================================
	// Beat within the line, then the set index, then the tag
	localparam int BEAT_LO = 4;
	localparam int BEAT_HI = 5;
	localparam int SET_LO  = 6;
	localparam int SET_HI  = 9;
	localparam int TAG_LO  = 10;
	localparam int TAG_HI  = ADDR_W - 1;
	localparam int TAG_W   = ADDR_W - TAG_LO;

	// Slot number sits above the beat number in every id
	localparam int TID_W       = LOG_SLOTS + LOG_BEATS;
	localparam int TID_BEAT_LO = 0;
	localparam int TID_BEAT_HI = LOG_BEATS - 1;
	localparam int TID_SLOT_LO = LOG_BEATS;
	localparam int TID_SLOT_HI = TID_W - 1;

	// Replacement LFSR, the seed only has to be non-zero
	localparam int LFSR_W = 17;
	localparam logic [LFSR_W-1:0] LFSR_SEED = 17'h0ace1;

	// Miss requester states
	typedef enum logic {
		REQ_IDLE,
		REQ_ISSUE
	} req_state_t;

endpackage

`default_nettype wire

// ==== lfsr17.sv ====
/*
 * Replacement LFSR
 * Free-running 17-bit Fibonacci LFSR with taps at 17 and 14, used
 * as the pseudo-random way selector for line fills
 */
`timescale 1ns/1ps
`default_nettype none

module lfsr17
	import icache_fill_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	output logic [LFSR_W-1:0] o
);

	logic fb;

	// Taps 17 and 14 give the full 2^17-1 sequence
	assign fb = o[LFSR_W-1] ^ o[LFSR_W-4];

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o <= LFSR_SEED;
		else
			o <= {o[LFSR_W-2:0], fb};
	end

	// The all-zero state is a lock-up state the sequence can never leave
	a_never_zero: assert property (@(posedge clk) disable iff (rst) o != '0)
		else $error("lfsr17 reached the all-zero state");

endmodule

`default_nettype wire

// ==== icache_miss_requester.sv ====
/*
 * Instruction cache miss requester
 * Takes fetch misses, gives each one a free fill slot and issues the
 * four beat reads of the line with a slot and beat transaction id
 */
`timescale 1ns/1ps
`default_nettype none

module icache_miss_requester
	import icache_fill_pkg::*;
(
	input  wire                               clk,
	input  wire                               rst,
	input  wire                               miss,
	input  wire  [ADDR_W-1:0]                 miss_vadr,
	input  wire  [ADDR_W-1:0]                 miss_padr,
	output logic                              miss_ready,
	output logic                              req,
	output logic [ADDR_W-1:0]                 req_adr,
	output logic [TID_W-1:0]                  req_tid,
	output logic [NUM_SLOTS-1:0][TAG_W-1:0]   slot_vtag,
	input  wire                               wr_ic,
	input  wire  [LOG_SLOTS-1:0]              fill_slot
);

	req_state_t           state;
	logic [NUM_SLOTS-1:0] busy;
	logic [LOG_SLOTS-1:0] cur_slot;
	logic [LOG_SLOTS-1:0] free_slot;
	logic [LOG_BEATS-1:0] beat_cnt;
	logic [ADDR_W-1:SET_LO] line_adr;
	logic                 take;

	// ==========================================================
	// Slot allocation
	// ==========================================================
	// Scan downwards so the lowest free slot wins
	always_comb begin
		free_slot = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (!busy[i])
				free_slot = LOG_SLOTS'(i);
		end
	end

	// Ready only while idle and at least one slot is free
	assign miss_ready = (state == REQ_IDLE) && !(&busy);
	assign take = miss && miss_ready;

	// ==========================================================
	// Beat read issue
	// ==========================================================
	// One read per cycle while issuing, beat number goes into bits 5:4
	assign req     = (state == REQ_ISSUE);
	assign req_adr = {line_adr, beat_cnt, {BEAT_LO{1'b0}}};
	assign req_tid = {cur_slot, beat_cnt};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= REQ_IDLE;
			busy     <= '0;
			cur_slot <= '0;
			beat_cnt <= '0;
		end else begin
			// A completed line releases its slot
			if (wr_ic)
				busy[fill_slot] <= 1'b0;
			case (state)
			REQ_IDLE: begin
				if (take) begin
					busy[free_slot] <= 1'b1;
					cur_slot        <= free_slot;
					beat_cnt        <= '0;
					state           <= REQ_ISSUE;
				end
			end
			REQ_ISSUE: begin
				beat_cnt <= beat_cnt + 1'b1;
				// Last beat goes out this cycle
				if (&beat_cnt)
					state <= REQ_IDLE;
			end
			default: state <= REQ_IDLE;
			endcase
		end
	end

	// Line address and virtual tag of the accepted miss
	always_ff @(posedge clk) begin
		if (take) begin
			line_adr             <= miss_padr[ADDR_W-1:SET_LO];
			slot_vtag[free_slot] <= miss_vadr[TAG_HI:TAG_LO];
		end
	end

	// A miss offered while no slot can take it would be dropped
	a_miss_ready: assert property (@(posedge clk) disable iff (rst) miss |-> miss_ready)
		else $error("miss raised while not ready, requester %s", state.name());

endmodule

`default_nettype wire

// ==== icache_ack_processor.sv ====
/*
 * Instruction cache ack processor
 * Gathers out-of-order beat responses into per-slot line buffers and
 * hands each completed line to the cache array with a random way
 */
`timescale 1ns/1ps
`default_nettype none

module icache_ack_processor
	import icache_fill_pkg::*;
(
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              resp_ack,
	input  wire  [TID_W-1:0]                 resp_tid,
	input  wire  [ADDR_W-1:0]                resp_adr,
	input  wire  [BEAT_W-1:0]                resp_dat,
	input  wire  [NUM_SLOTS-1:0][TAG_W-1:0]  slot_vtag,
	input  wire  [LFSR_W-1:0]                lfsr_val,
	output logic                             wr_ic,
	output logic [LINE_W-1:0]                line_o,
	output logic [TAG_W-1:0]                 line_vtag,
	output logic [TAG_W-1:0]                 line_ptag,
	output logic [LOG_SETS-1:0]              line_set,
	output logic [LOG_WAYS-1:0]              way,
	output logic [LOG_SLOTS-1:0]             fill_slot
);

	// Per-slot beat valid bits and line buffers
	logic [NUM_BEATS-1:0] beat_v    [NUM_SLOTS];
	logic [LINE_W-1:0]    slot_line [NUM_SLOTS];
	logic [TAG_W-1:0]     slot_vt   [NUM_SLOTS];
	logic [TAG_W-1:0]     slot_pt   [NUM_SLOTS];
	logic [LOG_SETS-1:0]  slot_set  [NUM_SLOTS];

	logic [LOG_SLOTS-1:0] r_slot;
	logic [LOG_BEATS-1:0] r_beat;
	logic [LOG_BEATS-1:0] r_pos;
	logic                 done_any;
	logic [LOG_SLOTS-1:0] done_slot;

	// ==========================================================
	// Response decode
	// ==========================================================
	// The id names the slot and the request, the address places the data
	assign r_slot = resp_tid[TID_SLOT_HI:TID_SLOT_LO];
	assign r_beat = resp_tid[TID_BEAT_HI:TID_BEAT_LO];
	assign r_pos  = resp_adr[BEAT_HI:BEAT_LO];

	// Lowest slot with all four beats present goes first
	always_comb begin
		done_any  = 1'b0;
		done_slot = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (&beat_v[i]) begin
				done_any  = 1'b1;
				done_slot = LOG_SLOTS'(i);
			end
		end
	end

	// ==========================================================
	// Beat tracking and line hand-off
	// ==========================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ic <= 1'b0;
			for (int i = 0; i < NUM_SLOTS; i++)
				beat_v[i] <= '0;
		end else begin
			wr_ic <= done_any;
			// A sent slot starts empty for its next miss
			if (done_any)
				beat_v[done_slot] <= '0;
			if (resp_ack)
				beat_v[r_slot][r_beat] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_ack) begin
			slot_line[r_slot][r_pos*BEAT_W +: BEAT_W] <= resp_dat;
			slot_vt[r_slot] <= slot_vtag[r_slot];
			slot_pt[r_slot] <= resp_adr[TAG_HI:TAG_LO];
			// Index bits sit inside the page offset, virtual and physical agree
			slot_set[r_slot] <= resp_adr[SET_HI:SET_LO];
		end
		if (done_any) begin
			line_o    <= slot_line[done_slot];
			line_vtag <= slot_vt[done_slot];
			line_ptag <= slot_pt[done_slot];
			line_set  <= slot_set[done_slot];
			fill_slot <= done_slot;
			way       <= lfsr_val[LOG_WAYS-1:0];
		end
	end

	// Each beat read is answered once, a repeat would overwrite a live beat
	a_no_dup_beat: assert property (@(posedge clk) disable iff (rst)
		resp_ack |-> !beat_v[r_slot][r_beat])
		else $error("duplicate response for slot %0d beat %0d", r_slot, r_beat);

endmodule

`default_nettype wire

// ==== icache_ways.sv ====
/*
 * Instruction cache array
 * Four ways by sixteen sets of tag, physical tag, valid and line data,
 * written a whole line at a time and looked up combinationally
 */
`timescale 1ns/1ps
`default_nettype none

module icache_ways
	import icache_fill_pkg::*;
(
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  wr_ic,
	input  wire  [LINE_W-1:0]    line_o,
	input  wire  [TAG_W-1:0]     line_vtag,
	input  wire  [TAG_W-1:0]     line_ptag,
	input  wire  [LOG_SETS-1:0]  line_set,
	input  wire  [LOG_WAYS-1:0]  way,
	input  wire  [ADDR_W-1:0]    fetch_vadr,
	output logic                 fetch_hit,
	output logic [BEAT_W-1:0]    fetch_dat
);

	logic [TAG_W-1:0]    vtag_mem [NUM_WAYS][NUM_SETS];
	// Physical tags are kept for a later snoop compare
	logic [TAG_W-1:0]    ptag_mem [NUM_WAYS][NUM_SETS];
	logic [LINE_W-1:0]   data_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid    [NUM_WAYS];

	logic [LOG_SETS-1:0]  f_set;
	logic [TAG_W-1:0]     f_tag;
	logic [LOG_BEATS-1:0] f_beat;

	// ==========================================================
	// Line write
	// ==========================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++)
				valid[w] <= '0;
		end else if (wr_ic) begin
			valid[way][line_set] <= 1'b1;
		end
	end

	// The chosen way is simply replaced, whatever it held
	always_ff @(posedge clk) begin
		if (wr_ic) begin
			vtag_mem[way][line_set] <= line_vtag;
			ptag_mem[way][line_set] <= line_ptag;
			data_mem[way][line_set] <= line_o;
		end
	end

	// ==========================================================
	// Fetch lookup
	// ==========================================================
	assign f_set  = fetch_vadr[SET_HI:SET_LO];
	assign f_tag  = fetch_vadr[TAG_HI:TAG_LO];
	assign f_beat = fetch_vadr[BEAT_HI:BEAT_LO];

	// Compare the virtual tag in every way of the set
	always_comb begin
		fetch_hit = 1'b0;
		fetch_dat = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (valid[w][f_set] && vtag_mem[w][f_set] == f_tag) begin
				fetch_hit = 1'b1;
				fetch_dat = data_mem[w][f_set][f_beat*BEAT_W +: BEAT_W];
			end
		end
	end

endmodule

`default_nettype wire

// ==== icache_fill_top.sv ====
/*
 * Instruction cache line-fill top level
 * Connects the miss requester, ack processor, replacement LFSR and
 * the cache array into one fill path
 */
`timescale 1ns/1ps
`default_nettype none

module icache_fill_top
	import icache_fill_pkg::*;
(
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 miss,
	input  wire  [ADDR_W-1:0]   miss_vadr,
	input  wire  [ADDR_W-1:0]   miss_padr,
	output logic                miss_ready,
	output logic                req,
	output logic [ADDR_W-1:0]   req_adr,
	output logic [TID_W-1:0]    req_tid,
	input  wire                 resp_ack,
	input  wire  [TID_W-1:0]    resp_tid,
	input  wire  [ADDR_W-1:0]   resp_adr,
	input  wire  [BEAT_W-1:0]   resp_dat,
	input  wire  [ADDR_W-1:0]   fetch_vadr,
	output logic                fetch_hit,
	output logic [BEAT_W-1:0]   fetch_dat
);

	// ==========================================================
	// Internal fill path nets
	// ==========================================================
	logic [NUM_SLOTS-1:0][TAG_W-1:0] slot_vtag;
	logic                            wr_ic;
	logic [LINE_W-1:0]               line_o;
	logic [TAG_W-1:0]                line_vtag;
	logic [TAG_W-1:0]                line_ptag;
	logic [LOG_SETS-1:0]             line_set;
	logic [LOG_WAYS-1:0]             way;
	logic [LOG_SLOTS-1:0]            fill_slot;
	logic [LFSR_W-1:0]               lfsr_val;

	icache_miss_requester icache_miss_requester_i (
		.clk(clk), .rst(rst),
		.miss(miss), .miss_vadr(miss_vadr), .miss_padr(miss_padr),
		.miss_ready(miss_ready),
		.req(req), .req_adr(req_adr), .req_tid(req_tid),
		.slot_vtag(slot_vtag),
		.wr_ic(wr_ic), .fill_slot(fill_slot)
	);

	icache_ack_processor icache_ack_processor_i (
		.clk(clk), .rst(rst),
		.resp_ack(resp_ack), .resp_tid(resp_tid),
		.resp_adr(resp_adr), .resp_dat(resp_dat),
		.slot_vtag(slot_vtag), .lfsr_val(lfsr_val),
		.wr_ic(wr_ic), .line_o(line_o), .line_vtag(line_vtag),
		.line_ptag(line_ptag), .line_set(line_set), .way(way),
		.fill_slot(fill_slot)
	);

	// Free-running, so the way depends on when the line completes
	lfsr17 lfsr17_i (
		.clk(clk), .rst(rst), .o(lfsr_val)
	);

	icache_ways icache_ways_i (
		.clk(clk), .rst(rst),
		.wr_ic(wr_ic), .line_o(line_o), .line_vtag(line_vtag),
		.line_ptag(line_ptag), .line_set(line_set), .way(way),
		.fetch_vadr(fetch_vadr), .fetch_hit(fetch_hit), .fetch_dat(fetch_dat)
	);

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
/*
 * Bus memory model
 * Answers each beat read after 1 to 8 cycles. The earliest due read goes
 * first, so replies come back out of order and interleave between slots
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
	import icache_fill_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	input  wire               hold,
	input  wire               req,
	input  wire  [ADDR_W-1:0] req_adr,
	input  wire  [TID_W-1:0]  req_tid,
	output logic              resp_ack,
	output logic [TID_W-1:0]  resp_tid,
	output logic [ADDR_W-1:0] resp_adr,
	output logic [BEAT_W-1:0] resp_dat
);

	integer            seed;
	int unsigned       cycle;
	// Outstanding reads and the cycle in which each one becomes due
	logic [ADDR_W-1:0] pend_adr [$];
	logic [TID_W-1:0]  pend_tid [$];
	int unsigned       pend_due [$];

	initial begin
		seed     = 32'hb1c368cd;
		cycle    = 0;
		resp_ack = 1'b0;
		resp_tid = '0;
		resp_adr = '0;
		resp_dat = '0;
	end

	// Requests are taken and replies driven on the falling edge
	always @(negedge clk) begin
		int          pick;
		int unsigned delay;
		if (rst) begin
			pend_adr.delete();
			pend_tid.delete();
			pend_due.delete();
			resp_ack <= 1'b0;
		end else begin
			cycle = cycle + 1;
			pick  = -1;
			// Hold keeps every reply back so all fill slots can stay busy
			if (!hold) begin
				for (int i = 0; i < pend_due.size(); i++) begin
					if (pend_due[i] <= cycle && (pick < 0 || pend_due[i] < pend_due[pick]))
						pick = i;
				end
			end
			resp_ack <= (pick >= 0);
			if (pick >= 0) begin
				resp_tid <= pend_tid[pick];
				resp_adr <= pend_adr[pick];
				// Beat address in every 32-bit lane, XORed with the beat number
				resp_dat <= {(BEAT_W/ADDR_W){pend_adr[pick]}}
					^ BEAT_W'(pend_adr[pick][BEAT_HI:BEAT_LO]);
				pend_adr.delete(pick);
				pend_tid.delete(pick);
				pend_due.delete(pick);
			end
			if (req) begin
				delay = ({$random(seed)} % 8) + 1;
				pend_adr.push_back(req_adr);
				pend_tid.push_back(req_tid);
				pend_due.push_back(cycle + delay);
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_icache_fill.sv ====
/*
 * Instruction cache line-fill testbench
 * Directed tests of miss issue, out-of-order fills, slot exhaustion and
 * replacement within one set, with line data predicted from the address
 */
`timescale 1ns/1ps
`default_nettype none

module tb_icache_fill
	import icache_fill_pkg::*;
();

	logic              clk;
	logic              rst;
	logic              miss;
	logic [ADDR_W-1:0] miss_vadr;
	logic [ADDR_W-1:0] miss_padr;
	logic              miss_ready;
	logic              req;
	logic [ADDR_W-1:0] req_adr;
	logic [TID_W-1:0]  req_tid;
	logic              resp_ack;
	logic [TID_W-1:0]  resp_tid;
	logic [ADDR_W-1:0] resp_adr;
	logic [BEAT_W-1:0] resp_dat;
	logic [ADDR_W-1:0] fetch_vadr;
	logic              fetch_hit;
	logic [BEAT_W-1:0] fetch_dat;
	logic              hold;
	req_state_t        req_state;

	int                errors;
	// Every bus read seen since the last clear
	logic [ADDR_W-1:0] seen_adr [$];
	logic [TID_W-1:0]  seen_tid [$];

	icache_fill_top icache_fill_top_i (
		.clk(clk), .rst(rst),
		.miss(miss), .miss_vadr(miss_vadr), .miss_padr(miss_padr),
		.miss_ready(miss_ready),
		.req(req), .req_adr(req_adr), .req_tid(req_tid),
		.resp_ack(resp_ack), .resp_tid(resp_tid),
		.resp_adr(resp_adr), .resp_dat(resp_dat),
		.fetch_vadr(fetch_vadr), .fetch_hit(fetch_hit), .fetch_dat(fetch_dat)
	);

	tb_mem_model tb_mem_model_i (
		.clk(clk), .rst(rst), .hold(hold),
		.req(req), .req_adr(req_adr), .req_tid(req_tid),
		.resp_ack(resp_ack), .resp_tid(resp_tid),
		.resp_adr(resp_adr), .resp_dat(resp_dat)
	);

	// Requester state as shown when a wait runs out
	assign req_state = icache_fill_top_i.icache_miss_requester_i.state;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Bus read monitor that samples req at the falling edge where it is stable
	always @(negedge clk) begin
		if (!rst && req) begin
			seen_adr.push_back(req_adr);
			seen_tid.push_back(req_tid);
		end
	end

	// ============================================================
	// Helpers
	// ============================================================
	function automatic logic [ADDR_W-1:0] line_adr(input logic [TAG_W-1:0] tag,
		input logic [LOG_SETS-1:0] set);
		return {tag, set, {SET_LO{1'b0}}};
	endfunction

	// Each 32-bit lane carries the beat address, XORed with the beat number
	function automatic logic [BEAT_W-1:0] beat_data(input logic [ADDR_W-1:0] adr);
		return {(BEAT_W/ADDR_W){adr}} ^ BEAT_W'(adr[BEAT_HI:BEAT_LO]);
	endfunction

	task automatic check(input string name, input logic [BEAT_W-1:0] act,
		input logic [BEAT_W-1:0] exp);
		if (act !== exp) begin
			errors++;
			$display("FAIL t=%0t %s actual=%h expected=%h", $time, name, act, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timed out at %0t waiting for %s, requester in %s",
			$time, what, req_state.name());
	endtask

	task automatic wait_ready(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < 100 && !ok; n++) begin
			@(negedge clk);
			ok = miss_ready;
		end
		if (!ok)
			report_timeout("miss_ready");
	endtask

	// The miss is raised only at a falling edge where miss_ready is high
	task automatic issue_miss(input logic [ADDR_W-1:0] va, input logic [ADDR_W-1:0] pa);
		bit ok;
		wait_ready(ok);
		if (ok) begin
			miss      = 1'b1;
			miss_vadr = va;
			miss_padr = pa;
			@(negedge clk);
			miss = 1'b0;
		end
	endtask

	task automatic wait_reqs(input int count);
		int n;
		n = 0;
		while (seen_adr.size() < count && n < 200) begin
			@(posedge clk);
			n++;
		end
		if (seen_adr.size() < count)
			report_timeout("bus reads");
	endtask

	task automatic wait_hit(input logic [ADDR_W-1:0] va);
		bit hit;
		hit = 1'b0;
		for (int n = 0; n < 200 && !hit; n++) begin
			@(negedge clk);
			fetch_vadr = va;
			#1;
			hit = fetch_hit;
		end
		if (!hit)
			report_timeout("a fetch hit after the fill");
	endtask

	// All four beats must hit and carry the data of their physical beat address
	task automatic check_line(input logic [ADDR_W-1:0] va, input logic [ADDR_W-1:0] pa);
		for (int b = 0; b < NUM_BEATS; b++) begin
			@(negedge clk);
			fetch_vadr = va | (ADDR_W'(b) << BEAT_LO);
			#1;
			check("fetch_hit", BEAT_W'(fetch_hit), BEAT_W'(1));
			check("fetch_dat", fetch_dat, beat_data(pa | (ADDR_W'(b) << BEAT_LO)));
		end
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic test_reset();
		check("miss_ready", BEAT_W'(miss_ready), BEAT_W'(1));
		for (int n = 0; n < 8; n++) begin
			@(negedge clk);
			fetch_vadr = line_adr(TAG_W'(n * 377), LOG_SETS'(n)) | (ADDR_W'(n % 4) << BEAT_LO);
			#1;
			check("req", BEAT_W'(req), '0);
			check("fetch_hit", BEAT_W'(fetch_hit), '0);
		end
	endtask

	// Virtual and physical tags differ while the index bits agree
	task automatic test_single();
		logic [ADDR_W-1:0] va;
		logic [ADDR_W-1:0] pa;
		va = line_adr(22'h12345, 4'd2);
		pa = line_adr(22'h0abcd, 4'd2);
		seen_adr.delete();
		seen_tid.delete();
		issue_miss(va, pa);
		wait_reqs(NUM_BEATS);
		for (int b = 0; b < NUM_BEATS && b < seen_adr.size(); b++) begin
			// First miss after reset lands in slot 0
			check("req_tid", BEAT_W'(seen_tid[b]), BEAT_W'({LOG_SLOTS'(0), LOG_BEATS'(b)}));
			check("req_adr", BEAT_W'(seen_adr[b]), BEAT_W'(pa | (ADDR_W'(b) << BEAT_LO)));
		end
		wait_hit(va);
		check_line(va, pa);
		// The line is in the array by now, so any surplus read has shown up
		check("read count", BEAT_W'(seen_adr.size()), BEAT_W'(NUM_BEATS));
	endtask

	// Back-to-back misses let the random reply delays interleave the slots
	task automatic test_four_slots();
		logic [ADDR_W-1:0] va [NUM_SLOTS];
		logic [ADDR_W-1:0] pa [NUM_SLOTS];
		for (int i = 0; i < NUM_SLOTS; i++) begin
			va[i] = line_adr(TAG_W'(32'h100 + i), LOG_SETS'(4 + i));
			pa[i] = line_adr(TAG_W'(32'h2a0 + 3 * i), LOG_SETS'(4 + i));
		end
		for (int i = 0; i < NUM_SLOTS; i++)
			issue_miss(va[i], pa[i]);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			wait_hit(va[i]);
			check_line(va[i], pa[i]);
		end
	endtask

	task automatic test_full();
		logic [ADDR_W-1:0] va [NUM_SLOTS+1];
		logic [ADDR_W-1:0] pa [NUM_SLOTS+1];
		for (int i = 0; i <= NUM_SLOTS; i++) begin
			va[i] = line_adr(TAG_W'(32'h1c0 + i), LOG_SETS'(8 + i));
			pa[i] = line_adr(TAG_W'(32'h3f00 - i), LOG_SETS'(8 + i));
		end
		@(negedge clk);
		hold <= 1'b1;
		seen_adr.delete();
		seen_tid.delete();
		for (int i = 0; i < NUM_SLOTS; i++)
			issue_miss(va[i], pa[i]);
		wait_reqs(NUM_SLOTS * NUM_BEATS);
		// Every slot is waiting on held replies
		for (int n = 0; n < 10; n++) begin
			@(negedge clk);
			check("miss_ready", BEAT_W'(miss_ready), '0);
		end
		hold <= 1'b0;
		issue_miss(va[NUM_SLOTS], pa[NUM_SLOTS]);
		for (int i = 0; i <= NUM_SLOTS; i++) begin
			wait_hit(va[i]);
			check_line(va[i], pa[i]);
		end
	endtask

	// Lines are filled one after another, so the last one is the newest write
	task automatic test_same_set();
		logic [ADDR_W-1:0] va [NUM_WAYS+1];
		logic [ADDR_W-1:0] pa [NUM_WAYS+1];
		int                hits;
		hits = 0;
		for (int i = 0; i <= NUM_WAYS; i++) begin
			va[i] = line_adr(TAG_W'(32'h300 + i), 4'd13);
			pa[i] = line_adr(TAG_W'(32'h5380 + 7 * i), 4'd13);
		end
		for (int i = 0; i <= NUM_WAYS; i++) begin
			issue_miss(va[i], pa[i]);
			wait_hit(va[i]);
		end
		for (int i = 0; i <= NUM_WAYS; i++) begin
			@(negedge clk);
			fetch_vadr = va[i];
			#1;
			if (fetch_hit) begin
				hits++;
				check_line(va[i], pa[i]);
			end
		end
		if (hits > NUM_WAYS) begin
			errors++;
			$display("Set 13 holds %0d lines, more than its %0d ways", hits, NUM_WAYS);
		end
		@(negedge clk);
		fetch_vadr = va[NUM_WAYS];
		#1;
		check("fetch_hit", BEAT_W'(fetch_hit), BEAT_W'(1));
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		errors     = 0;
		rst        = 1'b1;
		miss       = 1'b0;
		miss_vadr  = '0;
		miss_padr  = '0;
		fetch_vadr = '0;
		hold       = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_reset();
		test_single();
		test_four_slots();
		test_full();
		test_same_set();
		$display("Line-fill tests finished with %0d error(s)", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
icache_fill_pkg.sv
lfsr17.sv
icache_miss_requester.sv
icache_ack_processor.sv
icache_ways.sv
icache_fill_top.sv
tb_mem_model.sv
tb_icache_fill.sv

// ==== Makefile ====
# Verilator build, run and lint of the instruction cache line-fill path

VERILATOR ?= verilator
TOP       ?= tb_icache_fill
RTL_TOP   ?= icache_fill_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SRCS := $(wildcard *.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, a run that stops early counts as a failure
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
